// File: common/cnn_macros.svh
`ifndef CNN_MACROS_SVH
`define CNN_MACROS_SVH

// image is square, width equals height
`define CNN_IMG_W 8
`define CNN_IN_CH 2
`define CNN_OUT_CH 2

// signed sample and weight width
`define CNN_PIX_W 8
`define CNN_BIAS_W 16
`define CNN_ACC_W 20

`define CNN_TAPS 9
`define CNN_COORD_W 4

`endif

// File: common/cnn_ctrl_pkg.sv
`default_nettype none
`include "cnn_macros.svh"

package cnn_ctrl_pkg;

	// position of an output pixel in the unpadded result
	typedef struct packed
	{
		logic [`CNN_COORD_W-1:0] row;
		logic [`CNN_COORD_W-1:0] col;
	} out_coord_t;

	// coefficient chain shifts while filling, frozen once held
	typedef enum logic
	{
		LOAD_FILL,
		LOAD_HELD
	} load_state_t;

endpackage

`default_nettype wire

// File: common/cnn_data_pkg.sv
`default_nettype none
`include "cnn_macros.svh"

package cnn_data_pkg;

	typedef logic signed [`CNN_PIX_W-1:0] sample_t;

	// channel 0 in the low bits
	typedef sample_t [`CNN_IN_CH-1:0] pixel_vec_t;

	// one weight per input channel, same layout as a pixel
	typedef sample_t [`CNN_IN_CH-1:0] weight_vec_t;

	typedef logic signed [`CNN_BIAS_W-1:0] bias_t;

	typedef logic signed [`CNN_ACC_W-1:0] acc_t;

	// tap 0 top-left, row-major
	typedef pixel_vec_t [`CNN_TAPS-1:0] window_t;

	// one output beat
	typedef struct packed
	{
		cnn_ctrl_pkg::out_coord_t coord;
		acc_t [`CNN_OUT_CH-1:0] result;
	} conv_out_t;

endpackage

`default_nettype wire

// File: logic/coef_loader.sv
`timescale 1ns/1ps
`default_nettype none

module coef_loader #(
	parameter type entry_t = logic [7:0],
	parameter int N = 4
) (
	input logic clk,
	input logic rst,
	input logic load_valid,
	input entry_t load_data,
	output entry_t [N-1:0] chain,
	output logic held
);
	import cnn_ctrl_pkg::*;

	localparam int cnt_w = $clog2(N + 1);
	localparam logic [cnt_w-1:0] last_word = cnt_w'(N - 1);

	load_state_t state;
	logic [cnt_w-1:0] count;

	// word 0 enters at the top and walks down to entry 0
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= LOAD_FILL;
			count <= '0;
			chain <= '0;
		end
		else if (state == LOAD_FILL && load_valid)
		begin
			for (int i = 0; i < N - 1; i++)
			begin
				chain[i] <= chain[i + 1];
			end
			chain[N - 1] <= load_data;
			if (count == last_word)
			begin
				state <= LOAD_HELD;
			end
			else
			begin
				count <= count + 1'b1;
			end
		end
	end

	// frozen until the next reset
	assign held = (state == LOAD_HELD);

endmodule

`default_nettype wire

// File: window/pixel_window.sv
`timescale 1ns/1ps
`default_nettype none
`include "cnn_macros.svh"

module pixel_window (
	input logic clk,
	input logic rst,
	input logic shift,
	input cnn_data_pkg::pixel_vec_t pix,
	output cnn_data_pkg::window_t window
);
	import cnn_data_pkg::*;

	// two full lines plus three pixels of the current line
	localparam int depth = 2 * `CNN_IMG_W + 3;

	pixel_vec_t chain [depth];

	// entry 0 is the newest pixel
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < depth; i++)
			begin
				chain[i] <= '0;
			end
		end
		else if (shift)
		begin
			chain[0] <= pix;
			for (int i = 1; i < depth; i++)
			begin
				chain[i] <= chain[i - 1];
			end
		end
	end

	// newest pixel is bottom-right, one line back per W entries
	always_comb
	begin
		for (int rr = 0; rr < 3; rr++)
		begin
			for (int cc = 0; cc < 3; cc++)
			begin
				window[rr * 3 + cc] = chain[(2 - rr) * `CNN_IMG_W + (2 - cc)];
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/scan_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "cnn_macros.svh"

module scan_ctrl (
	input logic clk,
	input logic rst,
	input logic pix_valid,
	input logic coef_ready,
	output logic accept,
	output logic win_valid,
	output cnn_ctrl_pkg::out_coord_t win_coord,
	output logic win_last
);
	localparam logic [`CNN_COORD_W-1:0] last_idx = `CNN_COORD_W'(`CNN_IMG_W - 1);
	localparam logic [`CNN_COORD_W-1:0] margin = `CNN_COORD_W'(2);

	logic [`CNN_COORD_W-1:0] row;
	logic [`CNN_COORD_W-1:0] col;
	logic full_window;

	// pixels before coefficients are loaded are dropped
	assign accept = pix_valid & coef_ready;

	assign full_window = (row >= margin) && (col >= margin);

	// raster position of the next pixel
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			row <= '0;
			col <= '0;
		end
		else if (accept)
		begin
			if (col == last_idx)
			begin
				col <= '0;
				// wraps into the next frame
				row <= (row == last_idx) ? '0 : row + 1'b1;
			end
			else
			begin
				col <= col + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			win_valid <= 1'b0;
			win_last <= 1'b0;
		end
		else
		begin
			win_valid <= accept && full_window;
			win_last <= accept && (row == last_idx) && (col == last_idx);
		end
	end

	// window origin is two rows up, two columns left
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			win_coord.row <= row - margin;
			win_coord.col <= col - margin;
		end
	end

endmodule

`default_nettype wire

// File: mac/conv_mac.sv
`timescale 1ns/1ps
`default_nettype none
`include "cnn_macros.svh"

module conv_mac (
	input logic clk,
	input logic rst,
	input cnn_data_pkg::window_t window,
	input cnn_data_pkg::weight_vec_t [`CNN_TAPS*`CNN_OUT_CH-1:0] weights,
	input cnn_data_pkg::bias_t [`CNN_OUT_CH-1:0] biases,
	input logic win_valid,
	input cnn_ctrl_pkg::out_coord_t win_coord,
	input logic win_last,
	output logic out_valid,
	output cnn_data_pkg::conv_out_t out_beat,
	output logic frame_done
);
	import cnn_data_pkg::*;

	// full-precision product of one sample and one weight
	typedef logic signed [2*`CNN_PIX_W-1:0] prod_t;

	acc_t tap_sum [`CNN_OUT_CH][`CNN_TAPS];
	acc_t ch_sum [`CNN_OUT_CH];

	// first level sums the input channels of one tap
	always_comb
	begin
		prod_t prod;
		for (int o = 0; o < `CNN_OUT_CH; o++)
		begin
			for (int t = 0; t < `CNN_TAPS; t++)
			begin
				tap_sum[o][t] = '0;
				for (int i = 0; i < `CNN_IN_CH; i++)
				begin
					prod = prod_t'(window[t][i])
						* prod_t'(weights[t * `CNN_OUT_CH + o][i]);
					tap_sum[o][t] = tap_sum[o][t] + acc_t'(prod);
				end
			end
		end
	end

	// second level adds all taps on top of the bias
	// wraps at the result width
	always_comb
	begin
		for (int o = 0; o < `CNN_OUT_CH; o++)
		begin
			ch_sum[o] = acc_t'($signed(biases[o]));
			for (int t = 0; t < `CNN_TAPS; t++)
			begin
				ch_sum[o] = ch_sum[o] + tap_sum[o][t];
			end
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			out_valid <= 1'b0;
			frame_done <= 1'b0;
		end
		else
		begin
			out_valid <= win_valid;
			frame_done <= win_valid & win_last;
		end
	end

	// held between windows
	always_ff @(posedge clk)
	begin
		if (win_valid)
		begin
			out_beat.coord <= win_coord;
			for (int o = 0; o < `CNN_OUT_CH; o++)
			begin
				out_beat.result[o] <= ch_sum[o];
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/conv3x3_layer.sv
`timescale 1ns/1ps
`default_nettype none
`include "cnn_macros.svh"

module conv3x3_layer (
	input logic clk,
	input logic rst,
	input logic weight_valid,
	input cnn_data_pkg::weight_vec_t weight_word,
	input logic bias_valid,
	input cnn_data_pkg::bias_t bias_word,
	input logic pix_valid,
	input cnn_data_pkg::pixel_vec_t pix,
	output logic coef_ready,
	output logic out_valid,
	output cnn_data_pkg::conv_out_t out_beat,
	output logic frame_done
);
	import cnn_data_pkg::*;
	import cnn_ctrl_pkg::*;

	weight_vec_t [`CNN_TAPS*`CNN_OUT_CH-1:0] weights;
	bias_t [`CNN_OUT_CH-1:0] biases;
	logic weights_held;
	logic biases_held;
	logic accept;
	window_t window;
	logic win_valid;
	out_coord_t win_coord;
	logic win_last;

	// word k is tap k/OUT_CH of output channel k mod OUT_CH
	coef_loader #(
		.entry_t(weight_vec_t),
		.N(`CNN_TAPS * `CNN_OUT_CH)
	) weight_loader (
		.clk(clk),
		.rst(rst),
		.load_valid(weight_valid),
		.load_data(weight_word),
		.chain(weights),
		.held(weights_held)
	);

	coef_loader #(
		.entry_t(bias_t),
		.N(`CNN_OUT_CH)
	) bias_loader (
		.clk(clk),
		.rst(rst),
		.load_valid(bias_valid),
		.load_data(bias_word),
		.chain(biases),
		.held(biases_held)
	);

	assign coef_ready = weights_held & biases_held;

	pixel_window pixel_window_inst (
		.clk(clk),
		.rst(rst),
		.shift(accept),
		.pix(pix),
		.window(window)
	);

	scan_ctrl scan_ctrl_inst (
		.clk(clk),
		.rst(rst),
		.pix_valid(pix_valid),
		.coef_ready(coef_ready),
		.accept(accept),
		.win_valid(win_valid),
		.win_coord(win_coord),
		.win_last(win_last)
	);

	conv_mac conv_mac_inst (
		.clk(clk),
		.rst(rst),
		.window(window),
		.weights(weights),
		.biases(biases),
		.win_valid(win_valid),
		.win_coord(win_coord),
		.win_last(win_last),
		.out_valid(out_valid),
		.out_beat(out_beat),
		.frame_done(frame_done)
	);

endmodule

`default_nettype wire

// File: sim/conv3x3_layer_asserts.sv
`timescale 1ns/1ps
`default_nettype none
`include "cnn_macros.svh"

module conv3x3_layer_asserts (
	input logic clk,
	input logic rst,
	input logic coef_ready,
	input logic out_valid,
	input logic frame_done,
	input cnn_data_pkg::conv_out_t out_beat
);
	localparam logic [`CNN_COORD_W-1:0] last_pos = `CNN_COORD_W'(`CNN_IMG_W - 3);

	// coefficients stay loaded until the next reset
	ready_kept: assert property (@(posedge clk) disable iff (rst) coef_ready |=> coef_ready)
		else $error("coef_ready fell outside reset");

	done_has_valid: assert property (@(posedge clk) disable iff (rst) frame_done |-> out_valid)
		else $error("frame_done without out_valid");

	// last window of a frame sits at the bottom-right corner
	done_at_corner: assert property (@(posedge clk) disable iff (rst)
		frame_done |-> (out_beat.coord.row == last_pos) && (out_beat.coord.col == last_pos))
		else $error("frame_done away from the last output position");

	valid_needs_ready: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> coef_ready)
		else $error("out_valid while coefficients are not loaded");

endmodule

bind conv3x3_layer conv3x3_layer_asserts conv3x3_layer_asserts_inst (
	.clk(clk),
	.rst(rst),
	.coef_ready(coef_ready),
	.out_valid(out_valid),
	.frame_done(frame_done),
	.out_beat(out_beat)
);

`default_nettype wire

// File: sim/tb_conv3x3_layer.sv
`timescale 1ns/1ps
`default_nettype none
`include "cnn_macros.svh"

module tb_conv3x3_layer;
	import cnn_data_pkg::*;
	import cnn_ctrl_pkg::*;

	localparam logic [31:0] seed = 32'h18bb_e945;
	localparam int drain_limit = 400;
	localparam int num_tests = 6;
	localparam int preload_pixels = 20;
	localparam int pat_rand = 0;
	localparam int pat_ones = 1;
	localparam int pat_extreme = 2;
	localparam int pat_ramp = 3;
	localparam int win_per_frame = (`CNN_IMG_W - 2) * (`CNN_IMG_W - 2);
	localparam logic [`CNN_COORD_W-1:0] last_coord = `CNN_COORD_W'(`CNN_IMG_W - 3);

	typedef struct {
		string name;
		int coef_mode;
		int pix_mode;
		int gap_pct;
		int frames;
	} test_row_t;

	logic clk = 1'b0;
	logic rst;
	logic weight_valid;
	weight_vec_t weight_word;
	logic bias_valid;
	bias_t bias_word;
	logic pix_valid;
	pixel_vec_t pix;
	logic coef_ready;
	logic out_valid;
	conv_out_t out_beat;
	logic frame_done;

	test_row_t tests [num_tests];
	logic [31:0] rand_state;
	string cur_name;
	int check_count;
	int error_count;
	int beat_count;
	int done_count;
	bit timed_out;
	bit model_ready;
	bit due_now;
	bit due_next;
	int row_m;
	int col_m;
	weight_vec_t model_w [`CNN_TAPS*`CNN_OUT_CH];
	bias_t model_b [`CNN_OUT_CH];
	pixel_vec_t frame_px [`CNN_IMG_W][`CNN_IMG_W];
	conv_out_t exp_q [$];

	conv3x3_layer conv3x3_layer_inst (
		.clk(clk),
		.rst(rst),
		.weight_valid(weight_valid),
		.weight_word(weight_word),
		.bias_valid(bias_valid),
		.bias_word(bias_word),
		.pix_valid(pix_valid),
		.pix(pix),
		.coef_ready(coef_ready),
		.out_valid(out_valid),
		.out_beat(out_beat),
		.frame_done(frame_done)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rand_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rand_state = x;
		return x;
	endfunction

	function automatic sample_t pattern_sample(input int mode, input logic [31:0] rnd,
		input int ramp);
		case (mode)
			pat_ones: return sample_t'(1);
			pat_extreme: return rnd[0] ? sample_t'(127) : sample_t'(-128);
			pat_ramp: return sample_t'(ramp);
			default: return sample_t'(rnd[7:0]);
		endcase
	endfunction

	function automatic bias_t pattern_bias(input int mode, input logic [31:0] rnd);
		case (mode)
			pat_ones: return bias_t'(1);
			pat_extreme: return rnd[0] ? bias_t'(32767) : bias_t'(-32768);
			default: return bias_t'(rnd[15:0]);
		endcase
	endfunction

	// bias plus the sum over taps and input channels, wrapped to the result width
	function automatic conv_out_t expected_beat(input int r, input int c);
		conv_out_t beat;
		int sum;
		beat.coord.row = `CNN_COORD_W'(r - 2);
		beat.coord.col = `CNN_COORD_W'(c - 2);
		for (int o = 0; o < `CNN_OUT_CH; o++)
		begin
			sum = int'($signed(model_b[o]));
			for (int t = 0; t < `CNN_TAPS; t++)
			begin
				for (int i = 0; i < `CNN_IN_CH; i++)
				begin
					sum += int'($signed(frame_px[r - 2 + t / 3][c - 2 + t % 3][i]))
						* int'($signed(model_w[t * `CNN_OUT_CH + o][i]));
				end
			end
			beat.result[o] = acc_t'(sum);
		end
		return beat;
	endfunction

	task automatic check_value(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("CHECK FAILED test=%s check=%s expected=%0h actual=%0h",
				cur_name, what, expected, actual);
		end
	endtask

	// raster model, out_valid must follow a completing accept by exactly one edge
	always @(negedge clk)
	begin : monitor
		conv_out_t exp_beat;
		logic last_pos;
		if (rst)
		begin
			row_m = 0;
			col_m = 0;
			due_now = 1'b0;
			due_next = 1'b0;
			exp_q.delete();
		end
		else
		begin
			last_pos = 1'b0;
			check_value("out_valid timing", 64'(due_now), 64'(out_valid));
			if (out_valid)
			begin
				beat_count++;
			end
			if (out_valid && exp_q.size() != 0)
			begin
				exp_beat = exp_q.pop_front();
				check_value("out_beat", 64'(exp_beat), 64'(out_beat));
				last_pos = (exp_beat.coord.row == last_coord) && (exp_beat.coord.col == last_coord);
			end
			check_value("frame_done", 64'(last_pos), 64'(frame_done));
			if (frame_done)
			begin
				done_count++;
			end
			due_now = due_next;
			due_next = 1'b0;
			if (pix_valid && model_ready)
			begin
				frame_px[row_m][col_m] = pix;
				if (row_m >= 2 && col_m >= 2)
				begin
					exp_q.push_back(expected_beat(row_m, col_m));
					due_next = 1'b1;
				end
				col_m++;
				if (col_m == `CNN_IMG_W)
				begin
					col_m = 0;
					row_m = (row_m == `CNN_IMG_W - 1) ? 0 : row_m + 1;
				end
			end
		end
	end

	task automatic apply_reset();
		@(posedge clk);
		rst <= 1'b1;
		weight_valid <= 1'b0;
		bias_valid <= 1'b0;
		pix_valid <= 1'b0;
		model_ready = 1'b0;
		beat_count = 0;
		done_count = 0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_value("coef_ready after reset", 64'(0), 64'(coef_ready));
		check_value("out_valid after reset", 64'(0), 64'(out_valid));
	endtask

	// biases first, so the last weight is the one that completes the load
	task automatic load_coefs(input int mode);
		weight_vec_t w;
		bias_t b;
		for (int k = 0; k < `CNN_OUT_CH; k++)
		begin
			b = pattern_bias(mode, next_rand());
			model_b[k] = b;
			@(posedge clk);
			bias_valid <= 1'b1;
			bias_word <= b;
			@(negedge clk);
			check_value("coef_ready during bias load", 64'(0), 64'(coef_ready));
		end
		for (int k = 0; k < `CNN_TAPS * `CNN_OUT_CH; k++)
		begin
			for (int i = 0; i < `CNN_IN_CH; i++)
			begin
				w[i] = pattern_sample(mode, next_rand(), 0);
			end
			model_w[k] = w;
			@(posedge clk);
			bias_valid <= 1'b0;
			weight_valid <= 1'b1;
			weight_word <= w;
			@(negedge clk);
			check_value("coef_ready during weight load", 64'(0), 64'(coef_ready));
		end
		@(posedge clk);
		weight_valid <= 1'b0;
		@(negedge clk);
		check_value("coef_ready after last weight", 64'(1), 64'(coef_ready));
		model_ready = 1'b1;
		// late words must leave the frozen chains alone
		for (int k = 0; k < 3; k++)
		begin
			@(posedge clk);
			weight_valid <= 1'b1;
			weight_word <= weight_vec_t'(next_rand());
			bias_valid <= 1'b1;
			bias_word <= bias_t'(next_rand());
		end
		@(posedge clk);
		weight_valid <= 1'b0;
		bias_valid <= 1'b0;
	endtask

	task automatic send_frames(input int frames, input int mode, input int gap_pct);
		pixel_vec_t px;
		logic [31:0] rnd;
		int ramp;
		for (int f = 0; f < frames; f++)
		begin
			for (int r = 0; r < `CNN_IMG_W; r++)
			begin
				for (int c = 0; c < `CNN_IMG_W; c++)
				begin
					rnd = next_rand();
					if (rnd % 100 < gap_pct)
					begin
						repeat (int'(rnd[25:24]) + 1)
						begin
							@(posedge clk);
							pix_valid <= 1'b0;
						end
					end
					for (int i = 0; i < `CNN_IN_CH; i++)
					begin
						ramp = (i == 0) ? (r * 16 + c + f) : -(r * 16 + c);
						px[i] = pattern_sample(mode, next_rand(), ramp);
					end
					@(posedge clk);
					pix_valid <= 1'b1;
					pix <= px;
				end
			end
		end
		@(posedge clk);
		pix_valid <= 1'b0;
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while ((exp_q.size() != 0 || due_now || due_next) && !timed_out)
		begin
			@(posedge clk);
			cycles++;
			if (cycles > drain_limit)
			begin
				$display("timeout in test %s: %0d output beats never arrived",
					cur_name, exp_q.size());
				error_count++;
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic run_test(input test_row_t row);
		pixel_vec_t px;
		int errors_before;
		cur_name = row.name;
		errors_before = error_count;
		apply_reset();
		// offered before the coefficients, so all of these are dropped
		for (int k = 0; k < preload_pixels; k++)
		begin
			for (int i = 0; i < `CNN_IN_CH; i++)
			begin
				px[i] = pattern_sample(pat_rand, next_rand(), 0);
			end
			@(posedge clk);
			pix_valid <= 1'b1;
			pix <= px;
		end
		@(posedge clk);
		pix_valid <= 1'b0;
		load_coefs(row.coef_mode);
		send_frames(row.frames, row.pix_mode, row.gap_pct);
		wait_drain();
		if (!timed_out)
		begin
			repeat (3) @(posedge clk);
			check_value("beat count", 64'(win_per_frame * row.frames), 64'(beat_count));
			check_value("frame_done count", 64'(row.frames), 64'(done_count));
		end
		$display("test %s: %0d beats, %0d frame_done pulses, %0d errors",
			row.name, beat_count, done_count, error_count - errors_before);
	endtask

	initial
	begin
		rst = 1'b1;
		weight_valid = 1'b0;
		weight_word = '0;
		bias_valid = 1'b0;
		bias_word = '0;
		pix_valid = 1'b0;
		pix = '0;
		rand_state = seed;
		check_count = 0;
		error_count = 0;
		timed_out = 1'b0;
		model_ready = 1'b0;
		tests[0] = '{"rand_single", pat_rand, pat_rand, 0, 1};
		tests[1] = '{"ones_ramp", pat_ones, pat_ramp, 0, 1};
		tests[2] = '{"extreme_values", pat_extreme, pat_extreme, 0, 1};
		tests[3] = '{"rand_gaps", pat_rand, pat_rand, 40, 1};
		tests[4] = '{"back_to_back", pat_rand, pat_rand, 0, 2};
		tests[5] = '{"extreme_gaps_two", pat_extreme, pat_rand, 25, 2};
		for (int t = 0; t < num_tests && !timed_out; t++)
		begin
			run_test(tests[t]);
		end
		$display("summary: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
		begin
			$display("TB PASSED");
		end
		else
		begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+common
common/cnn_ctrl_pkg.sv
common/cnn_data_pkg.sv
logic/coef_loader.sv
window/pixel_window.sv
logic/scan_ctrl.sv
mac/conv_mac.sv
logic/conv3x3_layer.sv
sim/conv3x3_layer_asserts.sv
sim/tb_conv3x3_layer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run the testbench, judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f compile.f --top-module tb_conv3x3_layer -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| echo "TB FAILED (build or simulation aborted)" >> sim.log

cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0
